/* c16_mem_pkg.sv */
/*
 * Shared widths and memory map of the C16 SDRAM glue.
 * SDRAM is word addressed (16 bit); download addresses count bytes.
 * ROM images sit above ROM_MEM_START; C16 RAM uses the lowest 64k bytes.
 */
package c16_mem_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int SDRAM_AW = 24;
	localparam int IOCTL_AW = 25;
	localparam int C16_AW   = 16;

	// byte address of the first ROM image in SDRAM
	localparam logic [IOCTL_AW-1:0] ROM_MEM_START = 25'h10000;

	// download index codes from the IO controller
	localparam logic [7:0] IDX_ROM    = 8'h00;
	localparam logic [7:0] IDX_PRG    = 8'h01;
	localparam logic [7:0] IDX_KERNAL = 8'h03;

	// ROM bank inside the ROM area, as seen by the C16 selects
	typedef enum logic [1:0] {
		KERNAL    = 2'd0,
		BASIC     = 2'd1,
		FUNC_LOW  = 2'd2,
		FUNC_HIGH = 2'd3
	} rom_bank_t;

	// shadowed zero page bytes, low byte of each pointer first
	localparam logic [C16_AW-1:0] ZP_ADDRS [8] = '{
		16'h002d, 16'h002e, 16'h002f, 16'h0030,
		16'h0031, 16'h0032, 16'h009d, 16'h009e
	};

endpackage

/* c16_mem_if.sv */
/*
 * Internal buses of the memory glue.
 * c16_bus_if carries the demultiplexed C16 DRAM cycle,
 * loader_mem_if the download side write request.
 */
`timescale 1ns/100ps

interface c16_bus_if;
	// address is only complete once CAS has fallen
	logic [c16_mem_pkg::C16_AW-1:0] addr;
	logic                           cas_active;
	logic                           rw;
	logic [7:0]                     dout;
	// one clock after CAS fall
	logic                           zp_strobe;

	modport source (output addr, cas_active, rw, dout, zp_strobe);
	modport sink   (input  addr, cas_active, rw, dout, zp_strobe);
endinterface

interface loader_mem_if;
	logic [c16_mem_pkg::IOCTL_AW-1:0] addr;
	logic [7:0]                       data;
	// held for one loader slot
	logic                             write;
	logic                             prg_done;

	modport source (output addr, data, write, prg_done);
	modport sink   (input  addr, data, write, prg_done);
endinterface

/* c16_bus_latch.sv */
/*
 * Demultiplexes the C16 DRAM address from RAS and CAS and aligns the
 * SDRAM slots to the bus cycle. clkref high is the C16 slot.
 * Strobes are expected to be synchronous to clk28.
 */
`timescale 1ns/100ps

module c16_bus_latch (
	input  logic            clk28,
	input  logic            pll_locked,
	input  logic            c16_ras_n_i,
	input  logic            c16_cas_n_i,
	input  logic            c16_rw_i,
	input  logic [7:0]      c16_a_i,
	input  logic [7:0]      c16_dout_i,
	c16_bus_if.source       bus,
	output logic            clkref_o
);

	logic       ras_d;
	logic       cas_d;
	logic [3:0] slot_cnt;
	logic       zp_strobe;
	logic [7:0] a_low;
	logic [7:0] a_hi;
	logic       ras_fall;
	logic       cas_fall;

	assign ras_fall = ras_d & ~c16_ras_n_i;
	assign cas_fall = cas_d & ~c16_cas_n_i;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			ras_d     <= 1'b1;
			cas_d     <= 1'b1;
			slot_cnt  <= 4'd0;
			zp_strobe <= 1'b0;
		end else begin
			ras_d     <= c16_ras_n_i;
			cas_d     <= c16_cas_n_i;
			// restart the slot sequence with every bus cycle
			if (ras_fall)
				slot_cnt <= 4'd0;
			else
				slot_cnt <= slot_cnt + 4'd1;
			zp_strobe <= cas_fall;
		end
	end

	// row byte on RAS, column byte on CAS
	always_ff @(posedge clk28) begin
		if (ras_fall)
			a_low <= c16_a_i;
		if (cas_fall)
			a_hi <= c16_a_i;
	end

	assign clkref_o       = slot_cnt[3];
	assign bus.addr       = {a_hi, a_low};
	assign bus.cas_active = ~c16_cas_n_i;
	assign bus.rw         = c16_rw_i;
	assign bus.dout       = c16_dout_i;
	assign bus.zp_strobe  = zp_strobe;

endmodule

/* reset_gen.sv */
/*
 * System reset for the C16 core.
 * Long reset on power up and IO controller reboot, short reset on
 * the reset buttons, ROM downloads and memory size changes.
 */
`timescale 1ns/100ps

module reset_gen #(
	parameter int unsigned LONG_RESET_CYCLES  = 28_000_000,
	parameter int unsigned SHORT_RESET_CYCLES = 65_536
) (
	input  logic clk28,
	input  logic pll_locked,
	input  logic reboot_i,
	input  logic reset_btn_i,
	input  logic osd_reset_i,
	input  logic rom_download_i,
	input  logic memory_16k_i,
	output logic c16_reset_o
);

	logic [31:0] reset_cnt;
	logic        last_mem16k;

	// follows the memory size setting to spot a change
	always_ff @(posedge clk28) begin
		last_mem16k <= memory_16k_i;
	end

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			reset_cnt <= 32'(LONG_RESET_CYCLES);
		end else if (reboot_i) begin
			reset_cnt <= 32'(LONG_RESET_CYCLES);
		end else if (reset_btn_i || osd_reset_i || rom_download_i ||
			(memory_16k_i != last_mem16k)) begin
			reset_cnt <= 32'(SHORT_RESET_CYCLES);
		end else if (reset_cnt != 32'd0) begin
			reset_cnt <= reset_cnt - 32'd1;
		end
	end

	assign c16_reset_o = (reset_cnt != 32'd0);

endmodule

/* prg_loader.sv */
/*
 * Turns IO controller download bytes into SDRAM writes in the loader slot.
 * No back pressure: bytes must arrive slower than one per 16 clocks.
 * PRG files start with their two byte load address; ROM index 0 skips
 * the first 16k, index 3 is a plain kernal image.
 */
`timescale 1ns/100ps

module prg_loader (
	input  logic                             clk28,
	input  logic                             pll_locked,
	input  logic                             clkref_i,
	input  logic                             ioctl_download_i,
	input  logic [7:0]                       ioctl_index_i,
	input  logic                             ioctl_wr_i,
	input  logic [c16_mem_pkg::IOCTL_AW-1:0] ioctl_addr_i,
	input  logic [7:0]                       ioctl_data_i,
	loader_mem_if.source                     ld,
	output logic                             rom_download_o,
	output logic                             c16_wait_o
);

	logic                             prg_download;
	logic                             rom_download;
	logic                             idx_rom;
	logic                             idx_kernal;
	logic                             byte_wanted;
	logic                             rom_restart;
	logic                             last_clkref;
	logic                             clkref_fall;
	logic                             clkref_rise;
	logic                             ram_wr;
	logic                             sdram_write;
	logic                             prg_dl_d;
	logic                             prg_done;
	logic [7:0]                       ram_data;
	logic [7:0]                       sdram_data;
	logic [c16_mem_pkg::IOCTL_AW-1:0] sdram_addr;

	// ------------------------------------------------------------
	// download kind
	// ------------------------------------------------------------
	assign idx_rom      = (ioctl_index_i == c16_mem_pkg::IDX_ROM);
	assign idx_kernal   = (ioctl_index_i == c16_mem_pkg::IDX_KERNAL);
	assign prg_download = ioctl_download_i && (ioctl_index_i == c16_mem_pkg::IDX_PRG);
	assign rom_download = ioctl_download_i && (idx_rom || idx_kernal);

	// the two header bytes of a PRG are the load address, not data
	assign byte_wanted = (prg_download && ioctl_addr_i > 25'h1) ||
		(rom_download && (idx_kernal || ioctl_addr_i >= 25'h4000));
	assign rom_restart = rom_download &&
		((idx_rom && ioctl_addr_i == 25'h4000) || (idx_kernal && ioctl_addr_i == '0));

	assign clkref_fall = last_clkref & ~clkref_i;
	assign clkref_rise = ~last_clkref & clkref_i;

	// ------------------------------------------------------------
	// slot handshake
	// ------------------------------------------------------------
	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			last_clkref <= 1'b0;
			ram_wr      <= 1'b0;
			sdram_write <= 1'b0;
			prg_dl_d    <= 1'b0;
			prg_done    <= 1'b0;
		end else begin
			last_clkref <= clkref_i;
			prg_dl_d    <= prg_download;
			prg_done    <= prg_dl_d & ~prg_download;
			// loader slot begins
			if (clkref_fall) begin
				sdram_write <= ram_wr;
				ram_wr      <= 1'b0;
			end
			if (clkref_rise)
				sdram_write <= 1'b0;
			// a new byte wins over the slot start
			if (ioctl_wr_i && byte_wanted)
				ram_wr <= 1'b1;
		end
	end

	// data and address
	always_ff @(posedge clk28) begin
		if (clkref_fall && ram_wr)
			sdram_data <= ram_data;
		if (clkref_rise && sdram_write)
			sdram_addr <= sdram_addr + 1'd1;
		if (ioctl_wr_i) begin
			ram_data <= ioctl_data_i;
			if (prg_download && ioctl_addr_i == '0)
				sdram_addr[7:0] <= ioctl_data_i;
			else if (prg_download && ioctl_addr_i == 25'h1)
				sdram_addr[c16_mem_pkg::IOCTL_AW-1:8] <=
					(c16_mem_pkg::IOCTL_AW-8)'(ioctl_data_i);
			if (rom_restart)
				sdram_addr <= c16_mem_pkg::ROM_MEM_START;
		end
	end

	assign ld.addr        = sdram_addr;
	assign ld.data        = sdram_data;
	assign ld.write       = sdram_write;
	assign ld.prg_done    = prg_done;
	assign rom_download_o = rom_download;
	assign c16_wait_o     = prg_download | rom_download;

endmodule

/* zp_shadow.sv */
/*
 * Zero page shadow of the BASIC end pointers.
 * After a PRG injection all four pointers point behind the program.
 * Reads of the shadowed bytes are served here and never from SDRAM.
 */
`timescale 1ns/100ps

module zp_shadow (
	input  logic        clk28,
	c16_bus_if.sink     bus,
	loader_mem_if.sink  ld,
	input  logic        rom_access_i,
	output logic        zp_hit_o,
	output logic [7:0]  zp_dout_o
);

	// pointers at 2d, 2f, 31 and 9d
	logic [15:0] zp_ptr [4];
	logic [7:0]  zp_sel;

	always_comb begin
		for (int i = 0; i < 8; i++)
			zp_sel[i] = (bus.addr == c16_mem_pkg::ZP_ADDRS[i]);
	end

	assign zp_hit_o = ~rom_access_i & (|zp_sel);

	// even entries are low bytes, odd entries high bytes
	always_comb begin
		zp_dout_o = 8'hff;
		for (int i = 0; i < 8; i++) begin
			if (zp_sel[i])
				zp_dout_o = zp_ptr[i / 2][8 * (i % 2) +: 8];
		end
	end

	// ------------------------------------------------------------
	// pointer update
	// ------------------------------------------------------------
	always_ff @(posedge clk28) begin
		if (ld.prg_done) begin
			// the loader address already sits one past the last program byte
			for (int k = 0; k < 4; k++)
				zp_ptr[k] <= ld.addr[15:0];
		end else if (bus.zp_strobe && !bus.rw) begin
			for (int i = 0; i < 8; i++) begin
				if (zp_sel[i])
					zp_ptr[i / 2][8 * (i % 2) +: 8] <= bus.dout;
			end
		end
	end

endmodule

/* mem_arbiter.sv */
/*
 * Shares the SDRAM between the C16 slot (clkref high) and the loader slot.
 * Purely combinational; the SDRAM controller samples in its own slot.
 * Cartridge ROM selections are not supported and read the kernal.
 */
`timescale 1ns/100ps

module mem_arbiter (
	c16_bus_if.sink                            bus,
	loader_mem_if.sink                         ld,
	input  logic                               clkref_i,
	input  logic                               memory_16k_i,
	input  logic                               c16_basic_sel_n_i,
	input  logic                               c16_kernal_sel_n_i,
	input  logic [13:0]                        c16_rom_addr_i,
	input  logic [3:0]                         c16_rom_sel_i,
	input  logic                               zp_hit_i,
	input  logic [7:0]                         zp_dout_i,
	input  logic [15:0]                        sdram_dout_i,
	output logic                               rom_access_o,
	output logic [c16_mem_pkg::SDRAM_AW-1:0]   sdram_addr_o,
	output logic [15:0]                        sdram_din_o,
	output logic                               sdram_we_o,
	output logic                               sdram_oe_o,
	output logic [1:0]                         sdram_ds_o,
	output logic [7:0]                         c16_din_o
);

	c16_mem_pkg::rom_bank_t              rom_bank;
	logic                                rom_access;
	logic [c16_mem_pkg::SDRAM_AW-1:0]    ram_addr;
	logic [c16_mem_pkg::SDRAM_AW-1:0]    rom_addr;
	logic                                c16_lsb;
	logic                                byte_lsb;

	assign rom_access   = (~c16_basic_sel_n_i | ~c16_kernal_sel_n_i) & bus.rw;
	assign rom_access_o = rom_access;

	always_comb begin
		casez ({c16_basic_sel_n_i, c16_rom_sel_i})
			5'b1_00??: rom_bank = c16_mem_pkg::KERNAL;
			5'b1_10??: rom_bank = c16_mem_pkg::FUNC_HIGH;
			5'b0_??00: rom_bank = c16_mem_pkg::BASIC;
			5'b0_??10: rom_bank = c16_mem_pkg::FUNC_LOW;
			default:   rom_bank = c16_mem_pkg::KERNAL;
		endcase
	end

	// ------------------------------------------------------------
	// C16 address mapping
	// ------------------------------------------------------------
	// 16k mode mirrors the RAM through the whole 64k map
	assign ram_addr = memory_16k_i ?
		{9'd0, 1'b0, bus.addr[13:7], 1'b0, bus.addr[6:1]} :
		{9'd0, bus.addr[15:1]};
	assign rom_addr = {8'd0, 1'b1, rom_bank, c16_rom_addr_i[13:1]};
	assign c16_lsb  = rom_access ? c16_rom_addr_i[0] : bus.addr[0];

	// ------------------------------------------------------------
	// slot multiplexer
	// ------------------------------------------------------------
	always_comb begin
		if (clkref_i) begin
			sdram_addr_o = rom_access ? rom_addr : ram_addr;
			sdram_din_o  = {bus.dout, bus.dout};
			// shadowed zero page bytes stay out of SDRAM
			sdram_we_o   = bus.cas_active & ~bus.rw & ~zp_hit_i;
			sdram_oe_o   = (bus.cas_active & bus.rw) | rom_access;
			byte_lsb     = c16_lsb;
		end else begin
			sdram_addr_o = ld.addr[c16_mem_pkg::IOCTL_AW-1:1];
			sdram_din_o  = {ld.data, ld.data};
			sdram_we_o   = ld.write;
			sdram_oe_o   = 1'b0;
			byte_lsb     = ld.addr[0];
		end
	end

	assign sdram_ds_o = {byte_lsb, ~byte_lsb};
	assign c16_din_o  = zp_hit_i ? zp_dout_i :
		(c16_lsb ? sdram_dout_i[15:8] : sdram_dout_i[7:0]);

endmodule

/* c16_mem_top.sv */
/*
 * Memory glue between the C16 core and a shared SDRAM.
 * The core, the SDRAM controller and the IO controller sit outside.
 */
`timescale 1ns/100ps

module c16_mem_top #(
	parameter int unsigned LONG_RESET_CYCLES  = 28_000_000,
	parameter int unsigned SHORT_RESET_CYCLES = 65_536
) (
	input  logic                             clk28,
	input  logic                             pll_locked,
	// C16 DRAM bus
	input  logic                             c16_ras_n_i,
	input  logic                             c16_cas_n_i,
	input  logic                             c16_rw_i,
	input  logic [7:0]                       c16_a_i,
	input  logic [7:0]                       c16_dout_i,
	output logic [7:0]                       c16_din_o,
	input  logic                             c16_basic_sel_n_i,
	input  logic                             c16_kernal_sel_n_i,
	input  logic [13:0]                      c16_rom_addr_i,
	input  logic [3:0]                       c16_rom_sel_i,
	output logic                             clkref_o,
	output logic                             c16_wait_o,
	output logic                             c16_reset_o,
	// reset sources and options
	input  logic                             reboot_i,
	input  logic                             reset_btn_i,
	input  logic                             osd_reset_i,
	input  logic                             memory_16k_i,
	// IO controller download
	input  logic                             ioctl_download_i,
	input  logic [7:0]                       ioctl_index_i,
	input  logic                             ioctl_wr_i,
	input  logic [c16_mem_pkg::IOCTL_AW-1:0] ioctl_addr_i,
	input  logic [7:0]                       ioctl_data_i,
	// SDRAM controller
	output logic [c16_mem_pkg::SDRAM_AW-1:0] sdram_addr_o,
	output logic [15:0]                      sdram_din_o,
	output logic                             sdram_we_o,
	output logic                             sdram_oe_o,
	output logic [1:0]                       sdram_ds_o,
	input  logic [15:0]                      sdram_dout_i
);

	logic       rom_download;
	logic       rom_access;
	logic       zp_hit;
	logic [7:0] zp_dout;

	c16_bus_if    bus ();
	loader_mem_if ld ();

	c16_bus_latch i_bus_latch (
		.clk28       (clk28),
		.pll_locked  (pll_locked),
		.c16_ras_n_i (c16_ras_n_i),
		.c16_cas_n_i (c16_cas_n_i),
		.c16_rw_i    (c16_rw_i),
		.c16_a_i     (c16_a_i),
		.c16_dout_i  (c16_dout_i),
		.bus         (bus.source),
		.clkref_o    (clkref_o)
	);

	reset_gen #(
		.LONG_RESET_CYCLES  (LONG_RESET_CYCLES),
		.SHORT_RESET_CYCLES (SHORT_RESET_CYCLES)
	) i_reset_gen (
		.clk28          (clk28),
		.pll_locked     (pll_locked),
		.reboot_i       (reboot_i),
		.reset_btn_i    (reset_btn_i),
		.osd_reset_i    (osd_reset_i),
		.rom_download_i (rom_download),
		.memory_16k_i   (memory_16k_i),
		.c16_reset_o    (c16_reset_o)
	);

	prg_loader i_prg_loader (
		.clk28            (clk28),
		.pll_locked       (pll_locked),
		.clkref_i         (clkref_o),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ld               (ld.source),
		.rom_download_o   (rom_download),
		.c16_wait_o       (c16_wait_o)
	);

	zp_shadow i_zp_shadow (
		.clk28        (clk28),
		.bus          (bus.sink),
		.ld           (ld.sink),
		.rom_access_i (rom_access),
		.zp_hit_o     (zp_hit),
		.zp_dout_o    (zp_dout)
	);

	mem_arbiter i_mem_arbiter (
		.bus                (bus.sink),
		.ld                 (ld.sink),
		.clkref_i           (clkref_o),
		.memory_16k_i       (memory_16k_i),
		.c16_basic_sel_n_i  (c16_basic_sel_n_i),
		.c16_kernal_sel_n_i (c16_kernal_sel_n_i),
		.c16_rom_addr_i     (c16_rom_addr_i),
		.c16_rom_sel_i      (c16_rom_sel_i),
		.zp_hit_i           (zp_hit),
		.zp_dout_i          (zp_dout),
		.sdram_dout_i       (sdram_dout_i),
		.rom_access_o       (rom_access),
		.sdram_addr_o       (sdram_addr_o),
		.sdram_din_o        (sdram_din_o),
		.sdram_we_o         (sdram_we_o),
		.sdram_oe_o         (sdram_oe_o),
		.sdram_ds_o         (sdram_ds_o),
		.c16_din_o          (c16_din_o)
	);

endmodule

/* c16_mem_checker.sv */
/*
 * Bound assertions on the memory glue top level.
 * Checks slot ownership of SDRAM writes, we/oe exclusion, the wait
 * level during downloads and the minimum power up reset length.
 */
`timescale 1ns/100ps

module c16_mem_checker (
	input logic       clk28,
	input logic       pll_locked,
	input logic       clkref_o,
	input logic       sdram_we_o,
	input logic       sdram_oe_o,
	input logic       c16_wait_o,
	input logic       ioctl_download_i,
	input logic [7:0] ioctl_index_i,
	input logic       c16_reset_o
);

	// cycles since pll lock, saturating
	logic [8:0] since_lock;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked)
			since_lock <= 9'd0;
		else if (since_lock != 9'h1ff)
			since_lock <= since_lock + 9'd1;
	end

	// loader writes stay in the loader slot
	assert property (@(posedge clk28) disable iff (!pll_locked)
		(clkref_o && c16_wait_o) |-> !sdram_we_o)
		else $error("SDRAM write in the C16 slot during a download");

	assert property (@(posedge clk28) disable iff (!pll_locked)
		!(sdram_we_o && sdram_oe_o))
		else $error("SDRAM we and oe high together");

	assert property (@(posedge clk28) disable iff (!pll_locked)
		c16_wait_o == (ioctl_download_i &&
			(ioctl_index_i == c16_mem_pkg::IDX_PRG ||
			 ioctl_index_i == c16_mem_pkg::IDX_ROM ||
			 ioctl_index_i == c16_mem_pkg::IDX_KERNAL)))
		else $error("c16_wait_o does not follow the download state");

	assert property (@(posedge clk28) disable iff (!pll_locked)
		(since_lock < 9'd200) |-> c16_reset_o)
		else $error("C16 reset released too early after lock");

endmodule

/* tb_c16_mem.sv */
/*
 * Testbench for the C16 SDRAM glue with a C16 bus model and an SDRAM model.
 * Inputs change on the falling clock edge; outputs are read there too.
 * The SDRAM model covers the lowest 64k words only.
 */
`timescale 1ns/100ps

module tb_c16_mem;

	localparam int CLK_PERIOD  = 10;
	localparam int TEST_CYCLES = 700 + 1000 + 150 + 300 + 800;
	localparam logic [31:0] SEED = 32'h3ecc_3f65;

	logic        clk28;
	logic        pll_locked;
	logic        c16_ras_n_i;
	logic        c16_cas_n_i;
	logic        c16_rw_i;
	logic [7:0]  c16_a_i;
	logic [7:0]  c16_dout_i;
	logic [7:0]  c16_din_o;
	logic        c16_basic_sel_n_i;
	logic        c16_kernal_sel_n_i;
	logic [13:0] c16_rom_addr_i;
	logic [3:0]  c16_rom_sel_i;
	logic        clkref_o;
	logic        c16_wait_o;
	logic        c16_reset_o;
	logic        reboot_i;
	logic        reset_btn_i;
	logic        osd_reset_i;
	logic        memory_16k_i;
	logic        ioctl_download_i;
	logic [7:0]  ioctl_index_i;
	logic        ioctl_wr_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  ioctl_data_i;
	logic [23:0] sdram_addr_o;
	logic [15:0] sdram_din_o;
	logic        sdram_we_o;
	logic        sdram_oe_o;
	logic [1:0]  sdram_ds_o;
	logic [15:0] sdram_dout_i;

	logic [15:0] mem [65536];
	logic        mem_filled;
	int          errors;
	int          tests_passed;
	int          tests_failed;
	int          test_num;
	logic [7:0]  prg_data [20];
	logic [7:0]  rom_data [16];

	c16_mem_top #(
		.LONG_RESET_CYCLES  (200),
		.SHORT_RESET_CYCLES (40)
	) i_dut (.*);

	bind c16_mem_top c16_mem_checker i_checker (.*);

	initial begin
		clk28 = 1'b0;
		forever #(CLK_PERIOD / 2) clk28 = ~clk28;
	end

	// ------------------------------------------------------------
	// SDRAM model
	// ------------------------------------------------------------
	function automatic logic [15:0] fill_word(int i);
		return 16'(i) ^ 16'ha55a;
	endfunction

	always @(posedge clk28) begin
		if (!mem_filled) begin
			for (int i = 0; i < 65536; i++)
				mem[i] <= fill_word(i);
			mem_filled <= 1'b1;
		end else if (sdram_we_o) begin
			if (sdram_ds_o[0])
				mem[sdram_addr_o[15:0]][7:0] <= sdram_din_o[7:0];
			if (sdram_ds_o[1])
				mem[sdram_addr_o[15:0]][15:8] <= sdram_din_o[15:8];
		end
	end

	// read data only while a read is requested
	assign sdram_dout_i = sdram_oe_o ? mem[sdram_addr_o[15:0]] : 16'hxxxx;

	// byte as stored in the model, even bytes in the low half
	function automatic logic [7:0] model_byte(int byte_addr);
		logic [15:0] w;
		w = mem[(byte_addr >> 1) & 16'hffff];
		return (byte_addr % 2 == 1) ? w[15:8] : w[7:0];
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_num++;
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %0d %s: passed", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed", test_num, name);
		end
	endtask

	// ------------------------------------------------------------
	// C16 bus and download drivers
	// ------------------------------------------------------------
	task automatic bus_cycle(input logic [15:0] addr, input logic write,
		input logic [7:0] wdata, output logic [7:0] rdata);
		rdata = 8'hxx;
		@(negedge clk28);
		c16_ras_n_i = 1'b0;
		c16_a_i     = addr[7:0];
		c16_rw_i    = ~write;
		c16_dout_i  = wdata;
		repeat (4) @(negedge clk28);
		c16_cas_n_i = 1'b0;
		c16_a_i     = addr[15:8];
		repeat (16) begin
			@(negedge clk28);
			// read data is valid in the C16 slot
			if (clkref_o)
				rdata = c16_din_o;
		end
		c16_cas_n_i = 1'b1;
		c16_ras_n_i = 1'b1;
		c16_rw_i    = 1'b1;
		repeat (4) @(negedge clk28);
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		@(negedge clk28);
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		@(negedge clk28);
		ioctl_wr_i = 1'b0;
		repeat (38) @(negedge clk28);
	endtask

	task automatic wait_reset_release(input int limit, output int cycles);
		cycles = 0;
		while (c16_reset_o && cycles < limit) begin
			@(negedge clk28);
			cycles++;
		end
		if (cycles >= limit) begin
			$display("reset never released within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic check_reset_length(input string what, input int got, input int exp);
		assert (got >= exp - 4 && got <= exp + 4) else begin
			$display("mismatch at %0t: %s lasted %0d cycles, expected about %0d",
				$time, what, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset();
		int e;
		int n;
		e = errors;
		wait_reset_release(400, n);
		check_reset_length("power up reset", n, 200);
		@(negedge clk28);
		reset_btn_i = 1'b1;
		@(negedge clk28);
		reset_btn_i = 1'b0;
		wait_reset_release(100, n);
		check_reset_length("button reset", n, 40);
		@(negedge clk28);
		memory_16k_i = 1'b1;
		@(negedge clk28);
		wait_reset_release(100, n);
		check_reset_length("memory size reset", n, 40);
		memory_16k_i = 1'b0;
		@(negedge clk28);
		wait_reset_release(100, n);
		report_test("reset", e);
	endtask

	task automatic test_prg();
		int e;
		int a;
		e = errors;
		@(negedge clk28);
		ioctl_index_i    = c16_mem_pkg::IDX_PRG;
		ioctl_download_i = 1'b1;
		send_byte(25'h0, 8'h01);
		send_byte(25'h1, 8'h10);
		for (int k = 0; k < 20; k++) begin
			prg_data[k] = 8'($urandom);
			send_byte(25'(k + 2), prg_data[k]);
		end
		@(negedge clk28);
		ioctl_download_i = 1'b0;
		repeat (4) @(negedge clk28);
		for (int k = 0; k < 20; k++) begin
			a = 16'h1001 + k;
			check_byte($sformatf("PRG byte at %h", a), model_byte(a), prg_data[k]);
		end
		// byte below the load address shares a word but must stay untouched
		check_byte("byte below PRG", model_byte(16'h1000), fill_word(16'h0800) & 16'h00ff);
		report_test("prg injection", e);
	endtask

	task automatic test_zp();
		int          e;
		logic [15:0] end_ptr;
		logic [7:0]  rd;
		e = errors;
		// pointers end one past the last program byte
		end_ptr = 16'h1001 + 16'd20;
		bus_cycle(16'h002d, 1'b0, 8'h00, rd);
		check_byte("zero page 2d", rd, end_ptr[7:0]);
		bus_cycle(16'h002e, 1'b0, 8'h00, rd);
		check_byte("zero page 2e", rd, end_ptr[15:8]);
		bus_cycle(16'h009d, 1'b1, 8'hab, rd);
		bus_cycle(16'h009d, 1'b0, 8'h00, rd);
		check_byte("zero page 9d", rd, 8'hab);
		check_byte("SDRAM at 9d", model_byte(16'h009d), fill_word(16'h004e) >> 8);
		report_test("zero page shadow", e);
	endtask

	task automatic test_ram();
		int          e;
		int          n;
		logic [15:0] addr;
		logic [15:0] w;
		logic [7:0]  d1;
		logic [7:0]  d2;
		logic [7:0]  rd;
		e    = errors;
		addr = 16'h3c85;
		d1   = 8'($urandom);
		d2   = ~d1;
		bus_cycle(addr, 1'b1, d1, rd);
		w = {1'b0, addr[15:1]};
		check_byte("64k RAM word 1e42", mem[w][15:8], d1);
		@(negedge clk28);
		memory_16k_i = 1'b1;
		@(negedge clk28);
		wait_reset_release(100, n);
		bus_cycle(addr, 1'b1, d2, rd);
		// 16k layout: row bits 13 to 7, a zero bit, then bits 6 to 1
		w = {2'b00, addr[13:7], 1'b0, addr[6:1]};
		check_byte("16k RAM word", mem[w][15:8], d2);
		bus_cycle(addr, 1'b0, 8'h00, rd);
		check_byte("16k RAM read", rd, d2);
		@(negedge clk28);
		memory_16k_i = 1'b0;
		@(negedge clk28);
		wait_reset_release(100, n);
		report_test("ram mapping", e);
	endtask

	task automatic test_rom();
		int         e;
		int         guard;
		logic [7:0] rd;
		e = errors;
		@(negedge clk28);
		ioctl_index_i    = c16_mem_pkg::IDX_KERNAL;
		ioctl_download_i = 1'b1;
		for (int k = 0; k < 16; k++) begin
			rom_data[k] = 8'($urandom);
			send_byte(25'(k), rom_data[k]);
		end
		@(negedge clk28);
		ioctl_download_i = 1'b0;
		check_byte("ROM byte 0 in SDRAM", model_byte(32'h10000), rom_data[0]);
		c16_kernal_sel_n_i = 1'b0;
		c16_rom_addr_i     = 14'h0006;
		guard = 0;
		@(negedge clk28);
		while (!clkref_o && guard < 32) begin
			@(negedge clk28);
			guard++;
		end
		if (guard >= 32) begin
			$display("clkref never reached the C16 slot");
			errors++;
		end
		rd = c16_din_o;
		check_byte("kernal ROM byte 6", rd, rom_data[6]);
		c16_kernal_sel_n_i = 1'b1;
		c16_rom_addr_i     = 14'h0;
		repeat (50) @(negedge clk28);
		report_test("rom mapping", e);
	endtask

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("simulation timed out before all tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		mem_filled         = 1'b0;
		errors             = 0;
		tests_passed       = 0;
		tests_failed       = 0;
		test_num           = 0;
		pll_locked         = 1'b0;
		c16_ras_n_i        = 1'b1;
		c16_cas_n_i        = 1'b1;
		c16_rw_i           = 1'b1;
		c16_a_i            = 8'h00;
		c16_dout_i         = 8'h00;
		c16_basic_sel_n_i  = 1'b1;
		c16_kernal_sel_n_i = 1'b1;
		c16_rom_addr_i     = 14'h0;
		c16_rom_sel_i      = 4'h0;
		reboot_i           = 1'b0;
		reset_btn_i        = 1'b0;
		osd_reset_i        = 1'b0;
		memory_16k_i       = 1'b0;
		ioctl_download_i   = 1'b0;
		ioctl_index_i      = 8'hff;
		ioctl_wr_i         = 1'b0;
		ioctl_addr_i       = 25'h0;
		ioctl_data_i       = 8'h00;
		repeat (3) @(negedge clk28);
		pll_locked = 1'b1;

		test_reset();
		test_prg();
		test_zp();
		test_ram();
		test_rom();

		$display("%0d tests passed, %0d tests failed, %0d checks failed",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* vlog.f */
c16_mem_pkg.sv
c16_mem_if.sv
c16_bus_latch.sv
reset_gen.sv
prg_loader.sv
zp_shadow.sv
mem_arbiter.sv
c16_mem_top.sv
c16_mem_checker.sv
tb_c16_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the C16 memory glue testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_c16_mem -o sim_tb_c16_mem
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output="$(./obj_dir/sim_tb_c16_mem)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
